// File: l2_ctrl_pkg.sv
// cache controller enums, way and word types and address field sizes, imported by the rtl
`default_nettype none

package l2_ctrl_pkg;

    // client operations
    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_inv
    } op_e;

    // main controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_check_dirty,
        st_writeback,
        st_refill_req,
        st_refill_wait,
        st_invalidate
    } state_e;

    typedef logic [1:0] way_t;   // one of four ways
    typedef logic [1:0] word_t;  // word inside a line

    localparam int addr_w     = 16;  // word address
    localparam int line_words = 4;

endpackage

`default_nettype wire

// File: l2_bus_pkg.sv
// client and memory port payloads, shared by the cache top, its fsm and the testbench
`default_nettype none

package l2_bus_pkg;

    // client side
    typedef struct packed {
        l2_ctrl_pkg::op_e                op;
        logic [l2_ctrl_pkg::addr_w-1:0]  addr;   // word address
        logic [31:0]                     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;  // zero for write and invalidate
    } cpu_rsp_t;

    // memory side, one word per transfer
    typedef struct packed {
        logic                            we;
        logic [l2_ctrl_pkg::addr_w-1:0]  addr;
        logic [31:0]                     wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: l2_beat_counter.sv
// word beat counter for line writeback and refill bursts, driven by the cache fsm
`default_nettype none
`timescale 1ns/1ns

module l2_beat_counter (
    input  logic                clk,
    input  logic                rstn,
    input  logic                beat_start,
    input  logic                beat_step,
    output l2_ctrl_pkg::word_t  beat_word,
    output logic                beat_last
);
    import l2_ctrl_pkg::*;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_word <= '0;
        end else if (beat_start) begin
            beat_word <= '0;
        end else if (beat_step) begin
            beat_word <= beat_word + word_t'(1);  // wraps after last beat
        end
    end

    assign beat_last = (beat_word == word_t'(line_words - 1));

endmodule

`default_nettype wire

// File: l2_tag_dirty_array.sv
// tag, valid and dirty storage with registered hit compare, instantiated by the cache top
`default_nettype none
`timescale 1ns/1ns

module l2_tag_dirty_array #(
    parameter  int index_bits = 4,
    localparam int tag_bits   = l2_ctrl_pkg::addr_w - index_bits - 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_bits-1:0]  index,
    input  l2_ctrl_pkg::way_t      sel_way,
    input  logic                   tag_we,
    input  logic [tag_bits-1:0]    tag_value,
    input  logic                   dirty_set,
    input  logic                   valid_clear,
    input  logic [tag_bits-1:0]    req_tag,
    output logic [3:0]             hit,
    output logic [tag_bits-1:0]    victim_tag,
    output logic                   victim_dirty
);
    localparam int sets = 1 << index_bits;

    logic [tag_bits-1:0]    tag_mem [sets][4];
    logic [sets-1:0][3:0]   valid_q;
    logic [sets-1:0][3:0]   dirty_q;

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[index][sel_way] <= tag_value;
        end
        victim_tag <= tag_mem[index][sel_way];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q      <= '0;
            dirty_q      <= '0;
            hit          <= '0;
            victim_dirty <= 1'b0;
        end else begin
            if (tag_we) begin  // refilled line, valid and clean
                valid_q[index][sel_way] <= 1'b1;
                dirty_q[index][sel_way] <= 1'b0;
            end
            if (dirty_set) begin
                dirty_q[index][sel_way] <= 1'b1;
            end
            if (valid_clear) begin
                valid_q[index][sel_way] <= 1'b0;
                dirty_q[index][sel_way] <= 1'b0;
            end
            victim_dirty <= dirty_q[index][sel_way];
            // a tag written this cycle is compared directly
            for (int w = 0; w < 4; w++) begin
                if (tag_we && sel_way == 2'(w)) begin
                    hit[w] <= (tag_value == req_tag);
                end else begin
                    hit[w] <= valid_q[index][w] && (tag_mem[index][w] == req_tag);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: l2_data_array.sv
// line data storage with word and refill writes and a registered word read
`default_nettype none
`timescale 1ns/1ns

module l2_data_array #(
    parameter int index_bits = 4
) (
    input  logic                   clk,
    input  logic [index_bits-1:0]  index,
    input  l2_ctrl_pkg::way_t      sel_way,
    input  l2_ctrl_pkg::word_t     sel_word,
    input  logic                   word_we,
    input  logic [31:0]            wdata,
    input  logic                   fill_we,
    input  logic [31:0]            fill_data,
    output logic [31:0]            rd_word_data
);
    import l2_ctrl_pkg::*;

    localparam int depth = (1 << index_bits) * 4 * line_words;

    logic [31:0]               mem [depth];
    logic [$clog2(depth)-1:0]  addr;

    assign addr = {index, sel_way, sel_word};  // set, way, word

    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem[addr] <= fill_data;
        end else if (word_we) begin
            mem[addr] <= wdata;
        end
        rd_word_data <= mem[addr];  // hit data and writeback beats
    end

endmodule

`default_nettype wire

// File: l2_plru.sv
// tree pseudo-lru per set for four ways, gives the replacement victim to the fsm
`default_nettype none
`timescale 1ns/1ns

module l2_plru #(
    parameter int index_bits = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_bits-1:0]  index,
    input  logic                   use_strobe,
    input  l2_ctrl_pkg::way_t      use_way,
    output l2_ctrl_pkg::way_t      victim_way
);
    // bit 0 is the root, bit 1 picks in ways 0/1, bit 2 in ways 2/3
    logic [(1 << index_bits)-1:0][2:0] tree_q;
    logic [2:0]                        node;

    assign node       = tree_q[index];
    assign victim_way = node[0] ? {1'b1, node[2]} : {1'b0, node[1]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tree_q <= '0;
        end else if (use_strobe) begin
            tree_q[index][0] <= ~use_way[1];  // point away from used half
            if (use_way[1]) begin
                tree_q[index][2] <= ~use_way[0];
            end else begin
                tree_q[index][1] <= ~use_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: l2_ctrl_fsm.sv
// main cache fsm for lookup, hit service, dirty writeback, refill and invalidate
`default_nettype none
`timescale 1ns/1ns

module l2_ctrl_fsm #(
    parameter  int index_bits = 4,
    localparam int tag_bits   = l2_ctrl_pkg::addr_w - index_bits - 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   cpu_req_valid,
    output logic                   cpu_req_ready,
    input  l2_bus_pkg::cpu_req_t   cpu_req,
    output logic                   cpu_rsp_valid,
    input  logic                   cpu_rsp_ready,
    output l2_bus_pkg::cpu_rsp_t   cpu_rsp,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output l2_bus_pkg::mem_req_t   mem_req,
    input  logic                   mem_rsp_valid,
    output logic                   mem_rsp_ready,
    input  l2_bus_pkg::mem_rsp_t   mem_rsp,
    input  logic [3:0]             hit,
    input  logic [tag_bits-1:0]    victim_tag,
    input  logic                   victim_dirty,
    input  l2_ctrl_pkg::way_t      victim_way,
    input  logic [31:0]            rd_word_data,
    input  l2_ctrl_pkg::word_t     beat_word,
    input  logic                   beat_last,
    output logic [index_bits-1:0]  index,
    output l2_ctrl_pkg::way_t      sel_way,
    output l2_ctrl_pkg::word_t     sel_word,
    output logic                   word_we,
    output logic                   fill_we,
    output logic [31:0]            fill_data,
    output logic                   tag_we,
    output logic [tag_bits-1:0]    tag_value,
    output logic                   dirty_set,
    output logic                   valid_clear,
    output logic                   use_strobe,
    output logic                   beat_start,
    output logic                   beat_step
);
    import l2_ctrl_pkg::*;
    import l2_bus_pkg::*;

    state_e                 state;
    state_e                 state_nx;
    cpu_req_t               req_q;
    way_t                   way_q;     // hit way or miss victim
    logic                   run_q;
    way_t                   hit_way;
    logic [index_bits-1:0]  req_index;
    logic [tag_bits-1:0]    req_tag;
    word_t                  req_word;

    assign req_word  = req_q.addr[1:0];
    assign req_index = req_q.addr[index_bits+1:2];
    assign req_tag   = req_q.addr[addr_w-1:index_bits+2];

    // lookup starts with the incoming request while idle
    assign index     = (state == st_idle) ? cpu_req.addr[index_bits+1:2] : req_index;
    assign tag_value = (state == st_idle) ? cpu_req.addr[addr_w-1:index_bits+2] : req_tag;

    assign fill_data     = (state == st_refill_wait) ? mem_rsp.rdata : req_q.wdata;
    assign cpu_rsp.rdata = (req_q.op == op_read) ? rd_word_data : '0;

    always_comb begin
        hit_way = '0;
        for (int w = 3; w >= 0; w--) begin
            if (hit[w]) hit_way = way_t'(w);  // lowest way wins
        end
    end

    ////////////////////////////////////////
    // state and request registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            run_q <= 1'b0;
            way_q <= '0;
        end else begin
            state <= state_nx;
            run_q <= 1'b1;
            if (state == st_lookup) begin
                way_q <= sel_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
    end

    ////////////////////////////////////////
    // next state and array controls
    ////////////////////////////////////////

    always_comb begin
        state_nx      = state;
        cpu_req_ready = 1'b0;
        cpu_rsp_valid = 1'b0;
        mem_req_valid = 1'b0;
        mem_rsp_ready = 1'b0;
        mem_req.we    = 1'b0;
        mem_req.addr  = {req_tag, req_index, beat_word};
        mem_req.wdata = '0;
        sel_way       = way_q;
        sel_word      = req_word;
        word_we       = 1'b0;
        fill_we       = 1'b0;
        tag_we        = 1'b0;
        dirty_set     = 1'b0;
        valid_clear   = 1'b0;
        use_strobe    = 1'b0;
        beat_start    = 1'b0;
        beat_step     = 1'b0;
        case (state)
            st_idle: begin
                cpu_req_ready = run_q;
                if (cpu_req_valid && run_q) state_nx = st_lookup;
            end
            st_lookup: begin
                if (|hit) begin
                    sel_way = hit_way;
                    if (req_q.op == op_inv) begin
                        state_nx = st_check_dirty;
                    end else begin
                        use_strobe = 1'b1;
                        word_we    = (req_q.op == op_write);
                        dirty_set  = (req_q.op == op_write);
                        state_nx   = st_respond;
                    end
                end else begin
                    sel_way  = victim_way;  // dirty bit read for next state
                    state_nx = (req_q.op == op_inv) ? st_respond : st_check_dirty;
                end
            end
            st_check_dirty: begin
                beat_start = 1'b1;
                sel_word   = '0;  // prefetch first writeback word
                if (victim_dirty) begin
                    state_nx = st_writeback;
                end else if (req_q.op == op_inv) begin
                    state_nx = st_invalidate;
                end else begin
                    state_nx = st_refill_req;
                end
            end
            st_writeback: begin
                mem_req_valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = {victim_tag, req_index, beat_word};
                mem_req.wdata = rd_word_data;
                sel_word      = beat_word;
                if (mem_req_ready) begin
                    beat_step = 1'b1;
                    sel_word  = beat_word + word_t'(1);  // read ahead
                    if (beat_last) begin
                        state_nx = (req_q.op == op_inv) ? st_invalidate : st_refill_req;
                    end
                end
            end
            st_refill_req: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) state_nx = st_refill_wait;
            end
            st_refill_wait: begin
                mem_rsp_ready = 1'b1;
                sel_word      = beat_word;
                if (mem_rsp_valid) begin
                    fill_we   = 1'b1;
                    beat_step = 1'b1;
                    if (beat_last) begin
                        tag_we     = 1'b1;
                        use_strobe = 1'b1;
                        state_nx   = st_lookup;  // now hits
                    end else begin
                        state_nx = st_refill_req;
                    end
                end
            end
            st_invalidate: begin
                valid_clear = 1'b1;
                state_nx    = st_respond;
            end
            st_respond: begin
                cpu_rsp_valid = 1'b1;
                if (cpu_rsp_ready) state_nx = st_idle;
            end
            default: state_nx = st_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: l2_cache_top.sv
// four-way write-back l2 cache top, the DUT seen by the testbench
`default_nettype none
`timescale 1ns/1ns

module l2_cache_top #(
    parameter  int index_bits = 4,
    localparam int tag_bits   = l2_ctrl_pkg::addr_w - index_bits - 2
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cpu_req_valid,
    output logic                  cpu_req_ready,
    input  l2_bus_pkg::cpu_req_t  cpu_req,
    output logic                  cpu_rsp_valid,
    input  logic                  cpu_rsp_ready,
    output l2_bus_pkg::cpu_rsp_t  cpu_rsp,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output l2_bus_pkg::mem_req_t  mem_req,
    input  logic                  mem_rsp_valid,
    output logic                  mem_rsp_ready,
    input  l2_bus_pkg::mem_rsp_t  mem_rsp
);
    import l2_ctrl_pkg::*;

    logic [index_bits-1:0]  index;
    way_t                   sel_way;
    way_t                   victim_way;
    word_t                  sel_word;
    word_t                  beat_word;
    logic [3:0]             hit;
    logic [tag_bits-1:0]    victim_tag;
    logic [tag_bits-1:0]    tag_value;
    logic [31:0]            rd_word_data;
    logic [31:0]            fill_data;   // client or refill word
    logic                   victim_dirty;
    logic                   beat_last;
    logic                   word_we;
    logic                   fill_we;
    logic                   tag_we;
    logic                   dirty_set;
    logic                   valid_clear;
    logic                   use_strobe;
    logic                   beat_start;
    logic                   beat_step;

    l2_ctrl_fsm #(.index_bits(index_bits)) u_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req       (cpu_req),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_ready (cpu_rsp_ready),
        .cpu_rsp       (cpu_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .hit           (hit),
        .victim_tag    (victim_tag),
        .victim_dirty  (victim_dirty),
        .victim_way    (victim_way),
        .rd_word_data  (rd_word_data),
        .beat_word     (beat_word),
        .beat_last     (beat_last),
        .index         (index),
        .sel_way       (sel_way),
        .sel_word      (sel_word),
        .word_we       (word_we),
        .fill_we       (fill_we),
        .fill_data     (fill_data),
        .tag_we        (tag_we),
        .tag_value     (tag_value),
        .dirty_set     (dirty_set),
        .valid_clear   (valid_clear),
        .use_strobe    (use_strobe),
        .beat_start    (beat_start),
        .beat_step     (beat_step)
    );

    l2_beat_counter u_beat (
        .clk        (clk),
        .rstn       (rstn),
        .beat_start (beat_start),
        .beat_step  (beat_step),
        .beat_word  (beat_word),
        .beat_last  (beat_last)
    );

    // request tag doubles as the tag written on refill
    l2_tag_dirty_array #(.index_bits(index_bits)) u_tags (
        .clk          (clk),
        .rstn         (rstn),
        .index        (index),
        .sel_way      (sel_way),
        .tag_we       (tag_we),
        .tag_value    (tag_value),
        .dirty_set    (dirty_set),
        .valid_clear  (valid_clear),
        .req_tag      (tag_value),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    l2_data_array #(.index_bits(index_bits)) u_data (
        .clk          (clk),
        .index        (index),
        .sel_way      (sel_way),
        .sel_word     (sel_word),
        .word_we      (word_we),
        .wdata        (fill_data),
        .fill_we      (fill_we),
        .fill_data    (fill_data),
        .rd_word_data (rd_word_data)
    );

    l2_plru #(.index_bits(index_bits)) u_plru (
        .clk        (clk),
        .rstn       (rstn),
        .index      (index),
        .use_strobe (use_strobe),
        .use_way    (sel_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

// File: tb_l2_cache_chk.sv
// valid/ready protocol assertions, bound into the l2 cache top by the testbench build
`default_nettype none
`timescale 1ns/1ns

module tb_l2_cache_chk (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cpu_req_ready,
    input  logic                  cpu_rsp_valid,
    input  logic                  cpu_rsp_ready,
    input  l2_bus_pkg::cpu_rsp_t  cpu_rsp,
    input  logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  l2_bus_pkg::mem_req_t  mem_req
);
    // held response must not change before it is taken
    a_rsp_stable: assert property (@(posedge clk) disable iff (!rstn)
        cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp))
        else $error("cpu_rsp dropped or changed before cpu_rsp_ready");

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed before mem_req_ready");

    a_req_rsp_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(cpu_req_ready && cpu_rsp_valid))
        else $error("cpu_req_ready and cpu_rsp_valid high together");

    a_mem_idle: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_valid && cpu_req_ready))  // memory traffic only while busy
        else $error("mem_req_valid while cpu_req_ready is high");

endmodule

bind l2_cache_top tb_l2_cache_chk u_chk (
    .clk           (clk),
    .rstn          (rstn),
    .cpu_req_ready (cpu_req_ready),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp_ready (cpu_rsp_ready),
    .cpu_rsp       (cpu_rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req)
);

`default_nettype wire

// File: tb_l2_cache.sv
// testbench for the l2 cache top with a random-delay memory model and a shadow reference
`default_nettype none
`timescale 1ns/1ns

module tb_l2_cache;
    import l2_ctrl_pkg::*;
    import l2_bus_pkg::*;

    logic      clk;
    logic      rstn;
    logic      cpu_req_valid;
    logic      cpu_req_ready;
    cpu_req_t  cpu_req;
    logic      cpu_rsp_valid;
    logic      cpu_rsp_ready;
    cpu_rsp_t  cpu_rsp;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    mem_rsp_t  mem_rsp;

    logic [31:0]  mem_model [65536];
    logic [31:0]  shadow [65536];
    bit           written [65536];
    bit           touched [65536];
    logic [15:0]  touched_q [$];
    logic [31:0]  exp_q [$];
    logic [15:0]  exp_addr_q [$];
    logic [9:0]   tag_pool [6];
    int           edges = 0;
    int           acc_edge = 0;
    int           rsp_edge = 0;
    int           req_count = 0;
    int           rsp_count = 0;
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           err0 = 0;
    bit           bp_on = 1'b0;   // random back-pressure
    bit           rd_pend;
    bit           rsp_go;
    int           delay;
    logic [15:0]  rd_addr;

    l2_cache_top #(.index_bits(4)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) edges <= edges + 1;

    function automatic logic [31:0] fill_pattern(input logic [15:0] a);
        return {a ^ 16'h6b2d, ~a};
    endfunction

    // expected word: last write, else what memory started with
    function automatic logic [31:0] ref_read(input logic [15:0] a);
        return written[a] ? shadow[a] : fill_pattern(a);
    endfunction

    function automatic logic [15:0] make_addr(input logic [9:0] tag, input logic [3:0] idx,
                                              input logic [1:0] w);
        return {tag, idx, w};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic timeout_exit(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic send(input op_e op, input logic [15:0] addr, input logic [31:0] wdata);
        int n;
        n = 0;
        @(negedge clk);
        cpu_req_valid = 1'b1;
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        while (!cpu_req_ready && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_req_ready) begin
            timeout_exit("cpu_req_ready");
        end else begin
            acc_edge = edges + 1;  // transfer on the coming edge
            req_count++;
            exp_q.push_back(op == op_read ? ref_read(addr) : 32'h0);
            exp_addr_q.push_back(addr);
            if (op == op_write) begin
                shadow[addr]  = wdata;
                written[addr] = 1'b1;
            end
            if (!touched[addr]) begin
                touched[addr] = 1'b1;
                touched_q.push_back(addr);
            end
            @(negedge clk);
            cpu_req_valid = 1'b0;
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (rsp_count != req_count && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (rsp_count != req_count) timeout_exit(what);
    endtask

    task automatic start_test();
        tests++;
        err0 = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "mismatches");
    endtask

    ////////////////////////////////////////
    // response compare and cpu_rsp_ready
    ////////////////////////////////////////

    initial begin
        logic [31:0] exp;
        logic [15:0] a;
        cpu_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            cpu_rsp_ready = bp_on ? (($urandom % 3) != 0) : 1'b1;
            if (cpu_rsp_valid && cpu_rsp_ready) begin
                rsp_edge = edges + 1;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response at %0t arrived with no request outstanding", $time);
                end else begin
                    exp = exp_q.pop_front();
                    a   = exp_addr_q.pop_front();
                    check($sformatf("cpu_rsp.rdata @%h", a), cpu_rsp.rdata, exp);
                end
                rsp_count++;
            end
        end
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        rd_pend       = 1'b0;
        rsp_go        = 1'b0;
        delay         = 0;
        rd_addr       = '0;
        for (int i = 0; i < 65536; i++) mem_model[i] = fill_pattern(16'(i));
        forever begin
            @(negedge clk);
            if (rsp_go) begin  // taken on the last edge
                mem_rsp_valid = 1'b0;
                rsp_go        = 1'b0;
            end
            if (rd_pend) begin
                if (delay > 0) begin
                    delay--;
                end else begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.rdata = mem_model[rd_addr];
                    rd_pend       = 1'b0;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) rsp_go = 1'b1;
            mem_req_ready = bp_on ? (($urandom % 4) != 0) : 1'b1;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.we) begin
                    mem_model[mem_req.addr] = mem_req.wdata;
                end else begin
                    rd_pend = 1'b1;
                    rd_addr = mem_req.addr;
                    delay   = bp_on ? int'($urandom % 4) : 0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] evict_q [$];
        int          k;
        int          r;
        int          hits;
        op_e         op;
        void'($urandom(32'ha9bc));
        rstn          = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        for (int i = 0; i < 6; i++) tag_pool[i] = 10'(37 * i + 5);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        start_test();
        a = make_addr(10'h011, 4'd2, 2'd1);
        send(op_read, a, 32'h0);  // miss, refill
        wait_idle("read miss response");
        send(op_read, a, 32'h0);
        wait_idle("read hit response");
        check("cpu_rsp_valid latency", rsp_edge - acc_edge, 32'd2);
        end_test("read miss then hit");

        start_test();
        b = make_addr(10'h0c4, 4'd7, 2'd2);
        send(op_write, b, $urandom);
        send(op_write, a, $urandom);
        send(op_read, b, 32'h0);
        send(op_read, a, 32'h0);
        send(op_read, make_addr(10'h0c4, 4'd7, 2'd0), 32'h0);
        wait_idle("write allocate responses");
        end_test("write allocate and write hit");

        start_test();
        for (int i = 0; i < 5; i++) begin
            evict_q.push_back(make_addr(10'(40 + i), 4'd5, 2'd0));
            send(op_write, evict_q[i], $urandom);
        end
        wait_idle("eviction responses");
        hits = 0;
        foreach (evict_q[i]) begin
            if (mem_model[evict_q[i]] === ref_read(evict_q[i])) hits++;
        end
        check("lines written back", hits, 32'd1);  // five lines, four ways
        end_test("dirty eviction");

        start_test();
        a = make_addr(10'h2f3, 4'd9, 2'd3);
        send(op_write, a, $urandom);
        send(op_inv, a, 32'h0);
        wait_idle("invalidate response");
        check($sformatf("mem[%h]", a), mem_model[a], ref_read(a));
        send(op_read, a, 32'h0);
        wait_idle("read after invalidate");
        end_test("invalidate dirty line");

        start_test();
        bp_on = 1'b1;
        for (int n = 0; n < 400; n++) begin
            k = $urandom % 6;
            r = $urandom % 100;
            op = (r < 50) ? op_read : (r < 85) ? op_write : op_inv;
            a = make_addr(tag_pool[k], 4'($urandom % 4), 2'($urandom));
            send(op, a, $urandom);
            repeat ($urandom % 3) @(negedge clk);
        end
        wait_idle("random mix responses");
        foreach (touched_q[i]) send(op_inv, touched_q[i], 32'h0);
        wait_idle("final invalidate responses");
        foreach (touched_q[i]) begin
            check($sformatf("mem[%h]", touched_q[i]), mem_model[touched_q[i]],
                  ref_read(touched_q[i]));
        end
        end_test("random mix with back-pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
l2_ctrl_pkg.sv
l2_bus_pkg.sv
l2_beat_counter.sv
l2_tag_dirty_array.sv
l2_data_array.sv
l2_plru.sv
l2_ctrl_fsm.sv
l2_cache_top.sv
tb_l2_cache_chk.sv
tb_l2_cache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the l2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_l2_cache -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$out"; then
    exit 0
fi
exit 1
